// File: logic/data_logger.sv
`timescale 1ns/1ps

module data_logger (
    input  logic                 clk,
    input  logic                 reset,
    input  logger_pkg::sample_t  sample_in,
    input  logic                 sample_valid,
    input  logger_pkg::bus_req_t bus_req,
    output logger_pkg::bus_rsp_t bus_rsp
);

    import logger_pkg::*;

    log_record_t rec;
    logic        rec_valid;
    log_record_t head;
    logic        head_valid;
    fifo_count_t fill_count;
    logic [31:0] drop_count;
    logic        pop;

    // producer
    sample_stamper u_stamper (
        .clk          (clk),
        .reset        (reset),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .rec          (rec),
        .rec_valid    (rec_valid)
    );

    // buffer
    log_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .rec        (rec),
        .rec_valid  (rec_valid),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .fill_count (fill_count),
        .drop_count (drop_count)
    );

    // consumer, host side
    log_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .head       (head),
        .head_valid (head_valid),
        .fill_count (fill_count),
        .drop_count (drop_count),
        .pop        (pop)
    );

endmodule

// File: logic/log_fifo.sv
`timescale 1ns/1ps

module log_fifo (
    input  logic                    clk,
    input  logic                    reset,
    input  logger_pkg::log_record_t rec,
    input  logic                    rec_valid,
    input  logic                    pop,
    output logger_pkg::log_record_t head,
    output logic                    head_valid,
    output logger_pkg::fifo_count_t fill_count,
    output logic [31:0]             drop_count
);

    import logger_pkg::*;

    // ----------------------------------------
    // storage and pointers
    // ----------------------------------------

    log_record_t        mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    fifo_count_t        count_next;
    logic               full;
    logic               push_ok;
    logic               pop_ok;
    logic               drop;

    assign full   = (fill_count == fifo_count_t'(FIFO_DEPTH));
    assign pop_ok = pop && head_valid;

    // a full FIFO still takes a push when the head leaves at the same time
    assign push_ok = rec_valid && (!full || pop_ok);
    assign drop    = rec_valid && !push_ok;

    always_comb begin
        count_next = fill_count;
        case ({push_ok, pop_ok})
            2'b10:   count_next = fill_count + 1'b1;
            2'b01:   count_next = fill_count - 1'b1;
            default: count_next = fill_count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= rec;
        end
    end

    // first word falls through from the read pointer
    assign head = mem[rd_ptr];

    // ----------------------------------------
    // control state
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
            head_valid <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill_count <= count_next;
            head_valid <= (count_next != '0);
        end
    end

    // lost records
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_count <= '0;
        end else if (drop) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        fill_count <= fifo_count_t'(FIFO_DEPTH)
    );

    // pointer distance matches the count modulo the depth
    a_ptr_distance: assert property (
        @(posedge clk) disable iff (reset)
        (wr_ptr - rd_ptr) == fill_count[FIFO_AW-1:0]
    );

endmodule

// File: logic/log_regs.sv
`timescale 1ns/1ps

module log_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logger_pkg::bus_req_t    bus_req,
    output logger_pkg::bus_rsp_t    bus_rsp,
    input  logger_pkg::log_record_t head,
    input  logic                    head_valid,
    input  logger_pkg::fifo_count_t fill_count,
    input  logic [31:0]             drop_count,
    output logic                    pop
);

    import logger_pkg::*;

    // ----------------------------------------
    // control and limit registers
    // ----------------------------------------

    logic [CTL_W-1:0] ctl_q;
    fifo_count_t      limit_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_q   <= '0;
            limit_q <= '0;
        end else begin
            // pop request lasts a single cycle
            ctl_q[CTL_POP] <= 1'b0;
            if (bus_req.wr) begin
                case (bus_req.addr)
                    REG_CTL_CONTROL: begin
                        ctl_q <= bus_req.wdata[CTL_W-1:0];
                    end
                    REG_LIMIT_SIZE: begin
                        limit_q <= bus_req.wdata[FIFO_AW:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // read path
    // ----------------------------------------

    logic [BUS_AW-1:0] ch_off;
    logic              ch_hit;
    logic [CH_IW-1:0]  ch_idx;

    // channel window starts at REG_CH_BASE
    assign ch_off = bus_req.addr - REG_CH_BASE;
    assign ch_hit = (ch_off < BUS_AW'(NUM_CH));
    assign ch_idx = ch_off[CH_IW-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_rsp.rvalid <= 1'b0;
        end else begin
            bus_rsp.rvalid <= bus_req.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_rsp.rdata <= '0;
        end else if (bus_req.rd) begin
            case (bus_req.addr)
                REG_CORE_ID: begin
                    bus_rsp.rdata <= CORE_ID;
                end
                REG_CORE_VERSION: begin
                    bus_rsp.rdata <= CORE_VERSION;
                end
                REG_CTL_CONTROL: begin
                    bus_rsp.rdata <= BUS_DW'(ctl_q);
                end
                REG_CTL_STATUS: begin
                    bus_rsp.rdata <= BUS_DW'(head_valid);
                end
                REG_DROP_COUNT: begin
                    bus_rsp.rdata <= drop_count;
                end
                REG_CTL_COUNT: begin
                    bus_rsp.rdata <= BUS_DW'(fill_count);
                end
                REG_LIMIT_SIZE: begin
                    bus_rsp.rdata <= BUS_DW'(limit_q);
                end
                REG_READ_DATA: begin
                    // captured before the pop of the same cycle lands
                    bus_rsp.rdata <= head.ch[0];
                end
                REG_TIMER_LO: begin
                    bus_rsp.rdata <= head.timestamp[BUS_DW-1:0];
                end
                REG_TIMER_HI: begin
                    bus_rsp.rdata <= head.timestamp[TIMER_W-1:BUS_DW];
                end
                default: begin
                    if (ch_hit) begin
                        bus_rsp.rdata <= head.ch[ch_idx];
                    end else begin
                        bus_rsp.rdata <= '0;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------
    // pop sources
    // ----------------------------------------

    logic read_pop;
    logic trim_pop;

    assign read_pop = bus_req.rd && (bus_req.addr == REG_READ_DATA);

    // trim down to the limit one record per cycle
    assign trim_pop = (limit_q != '0) && (fill_count > limit_q);

    assign pop = ctl_q[CTL_POP] || ctl_q[CTL_FLUSH] || read_pop || trim_pop;

    // trimming never lets the buffer grow
    a_trim_no_growth: assert property (
        @(posedge clk) disable iff (reset)
        trim_pop |=> (fill_count <= $past(fill_count))
    );

endmodule

// File: logic/logger_pkg.sv
package logger_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------

    localparam int NUM_CH     = 4;
    localparam int CH_IW      = $clog2(NUM_CH);
    localparam int DATA_W     = 32;
    localparam int TIMER_W    = 64;
    localparam int FIFO_AW    = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;
    localparam int BUS_AW     = 8;
    localparam int BUS_DW     = 32;
    localparam int CTL_W      = 2;

    // identification words
    localparam logic [BUS_DW-1:0] CORE_ID      = 32'h527A_F002;
    localparam logic [BUS_DW-1:0] CORE_VERSION = 32'h0001_0000;

    // ----------------------------------------
    // data types
    // ----------------------------------------

    typedef logic [FIFO_AW:0] fifo_count_t;

    typedef logic [NUM_CH-1:0][DATA_W-1:0] ch_array_t;

    typedef struct packed {
        ch_array_t ch;
    } sample_t;

    // timestamp sits in the upper 64 bits
    typedef struct packed {
        logic [TIMER_W-1:0] timestamp;
        ch_array_t          ch;
    } log_record_t;

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [BUS_AW-1:0] addr;
        logic [BUS_DW-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              rvalid;
        logic [BUS_DW-1:0] rdata;
    } bus_rsp_t;

    // ----------------------------------------
    // register map, word indexes
    // ----------------------------------------

    typedef enum logic [BUS_AW-1:0] {
        REG_CORE_ID      = 8'h00,
        REG_CORE_VERSION = 8'h01,
        REG_CTL_CONTROL  = 8'h04,
        REG_CTL_STATUS   = 8'h05,
        REG_DROP_COUNT   = 8'h06,
        REG_CTL_COUNT    = 8'h07,
        REG_LIMIT_SIZE   = 8'h08,
        REG_READ_DATA    = 8'h10,
        REG_TIMER_LO     = 8'h18,
        REG_TIMER_HI     = 8'h19,
        REG_CH_BASE      = 8'h20
    } reg_addr_e;

    // bit positions inside the control register
    typedef enum logic [0:0] {
        CTL_POP   = 1'b0,
        CTL_FLUSH = 1'b1
    } ctl_bit_e;

endpackage

// File: logic/sample_stamper.sv
`timescale 1ns/1ps

module sample_stamper (
    input  logic                    clk,
    input  logic                    reset,
    input  logger_pkg::sample_t     sample_in,
    input  logic                    sample_valid,
    output logger_pkg::log_record_t rec,
    output logic                    rec_valid
);

    import logger_pkg::*;

    // ----------------------------------------
    // free-running cycle timer
    // ----------------------------------------

    logic [TIMER_W-1:0] timer;

    // zero in the first cycle after reset release
    always_ff @(posedge clk) begin
        if (reset) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // ----------------------------------------
    // record capture
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= sample_valid;
        end
    end

    // stamp holds the timer value of the strobe cycle
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            rec.timestamp <= timer;
            rec.ch        <= sample_in.ch;
        end
    end

    // a fresh record lags the running timer by one cycle
    a_stamp_matches_timer: assert property (
        @(posedge clk) disable iff (reset)
        rec_valid |-> (rec.timestamp == timer - TIMER_W'(1))
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the data logger testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

top=data_logger_tb
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -f vlog.f --top-module "$top" -Mdir "$build_dir" -o "$top"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

"./$build_dir/$top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: verification/data_logger_tb.sv
`timescale 1ns/1ps

module data_logger_tb;

    import logger_pkg::*;

    typedef enum logic [1:0] {
        OP_SAMPLE,
        OP_WRITE,
        OP_READ,
        OP_IDLE
    } op_e;

    // wdata doubles as the cycle count of an idle step
    typedef struct packed {
        op_e               kind;
        logic              from_model;
        logic [BUS_AW-1:0] addr;
        logic [BUS_DW-1:0] wdata;
        logic [BUS_DW-1:0] expected;
        sample_t           data;
    } step_t;

    logic     clk;
    logic     reset;
    sample_t  sample_in;
    logic     sample_valid;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    step_t       steps[$];
    log_record_t model_q[$];
    int          model_limit;
    logic [63:0] cyc;
    integer      seed;
    int          watch_cycles;
    int          timeout_limit;

    data_logger uut (
        .clk          (clk),
        .reset        (reset),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        watch_cycles = watch_cycles + 1;
        if (watch_cycles > timeout_limit) begin
            $display("timeout: the step table did not finish in %0d cycles", timeout_limit);
            $display("TB FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    // ----------------------------------------
    // checking and expected-record model
    // ----------------------------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic model_trim();
        if (model_limit != 0) begin
            while (model_q.size() > model_limit) begin
                model_q.delete(0);
            end
        end
    endtask

    // a full buffer drops the new record
    task automatic model_push(input sample_t d, input logic [63:0] stamp);
        log_record_t r;
        r.timestamp = stamp;
        r.ch        = d.ch;
        if (model_q.size() < FIFO_DEPTH) begin
            model_q.push_back(r);
        end
        model_trim();
    endtask

    task automatic model_write(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] wdata);
        if (addr == REG_CTL_CONTROL) begin
            if (wdata[CTL_FLUSH]) begin
                model_q.delete();
            end else if (wdata[CTL_POP] && model_q.size() > 0) begin
                model_q.delete(0);
            end
        end else if (addr == REG_LIMIT_SIZE) begin
            model_limit = int'(wdata[FIFO_AW:0]);
            model_trim();
        end
    endtask

    function automatic logic [31:0] model_value(input logic [BUS_AW-1:0] addr);
        log_record_t       r;
        logic [BUS_AW-1:0] off;
        r   = model_q[0];
        off = addr - REG_CH_BASE;
        case (addr)
            REG_READ_DATA: return r.ch[0];
            REG_TIMER_LO:  return r.timestamp[31:0];
            REG_TIMER_HI:  return r.timestamp[63:32];
            default:       return r.ch[off[CH_IW-1:0]];
        endcase
    endfunction

    // ----------------------------------------
    // table building and stepping
    // ----------------------------------------

    task automatic push_step(input op_e kind, input logic from_model,
                             input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] wdata,
                             input logic [BUS_DW-1:0] expected);
        step_t s;
        s.kind       = kind;
        s.from_model = from_model;
        s.addr       = addr;
        s.wdata      = wdata;
        s.expected   = expected;
        s.data       = '0;
        if (kind == OP_SAMPLE) begin
            for (int i = 0; i < NUM_CH; i++) begin
                s.data.ch[i] = $random(seed);
            end
        end
        steps.push_back(s);
    endtask

    task automatic add_read(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] value);
        push_step(OP_READ, 1'b0, addr, '0, value);
    endtask

    task automatic add_model_read(input logic [BUS_AW-1:0] addr);
        push_step(OP_READ, 1'b1, addr, '0, '0);
    endtask

    task automatic add_write(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] value);
        push_step(OP_WRITE, 1'b0, addr, value, '0);
    endtask

    task automatic add_idle(input int n);
        push_step(OP_IDLE, 1'b0, '0, n, '0);
    endtask

    task automatic add_samples(input int n);
        repeat (n) push_step(OP_SAMPLE, 1'b0, '0, '0, '0);
    endtask

    // inputs change 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
        cyc = cyc + 1;
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0] exp;
        string       name;
        case (s.kind)
            OP_SAMPLE: begin
                sample_in    = s.data;
                sample_valid = 1'b1;
                model_push(s.data, cyc);
                step_cycle();
                sample_valid = 1'b0;
            end
            OP_WRITE: begin
                bus_req.wr    = 1'b1;
                bus_req.addr  = s.addr;
                bus_req.wdata = s.wdata;
                model_write(s.addr, s.wdata);
                step_cycle();
                bus_req.wr = 1'b0;
                // no read was strobed in the write cycle
                check_value("bus_rsp.rvalid", 32'(bus_rsp.rvalid), 32'h0);
            end
            OP_READ: begin
                exp  = s.expected;
                name = $sformatf("bus_rsp.rdata at %h", s.addr);
                if (s.from_model) begin
                    if (model_q.size() == 0) begin
                        $display("the model holds no record to compare a head read with");
                        $display("TB FAILED");
                        $fatal(1, "empty model");
                    end
                    exp = model_value(s.addr);
                end
                if (s.addr == REG_READ_DATA && model_q.size() > 0) begin
                    model_q.delete(0);
                end
                bus_req.rd   = 1'b1;
                bus_req.addr = s.addr;
                step_cycle();
                bus_req.rd = 1'b0;
                while (!bus_rsp.rvalid) begin
                    step_cycle();
                end
                check_value(name, bus_rsp.rdata, exp);
            end
            default: begin
                repeat (s.wdata) step_cycle();
            end
        endcase
    endtask

    // ----------------------------------------
    // stimulus table and run
    // ----------------------------------------

    initial begin
        seed         = 32'h13b5fbb1;
        reset        = 1'b1;
        sample_in    = '0;
        sample_valid = 1'b0;
        bus_req      = '0;
        model_limit  = 0;
        cyc          = '0;
        watch_cycles = 0;

        // identification and reset state
        add_read(REG_CORE_ID, CORE_ID);
        add_read(REG_CORE_VERSION, CORE_VERSION);
        add_read(REG_CTL_STATUS, 0);
        add_read(REG_CTL_COUNT, 0);
        add_read(REG_DROP_COUNT, 0);
        add_read(REG_CTL_CONTROL, 0);
        add_read(REG_LIMIT_SIZE, 0);
        add_read(8'h3f, 0);

        // three samples with uneven gaps
        add_samples(1);
        add_idle(3);
        add_samples(1);
        add_idle(1);
        add_samples(1);
        add_idle(2);
        add_read(REG_CTL_COUNT, 3);
        add_read(REG_CTL_STATUS, 1);
        for (int i = 0; i < NUM_CH; i++) begin
            add_model_read(BUS_AW'(REG_CH_BASE + i));
        end
        add_model_read(REG_TIMER_LO);
        add_model_read(REG_TIMER_HI);

        // pop by data read and then by the pop bit
        add_model_read(REG_READ_DATA);
        add_read(REG_CTL_COUNT, 2);
        add_model_read(REG_TIMER_LO);
        add_write(REG_CTL_CONTROL, 32'h1);
        add_idle(2);
        add_read(REG_CTL_CONTROL, 0);
        add_read(REG_CTL_COUNT, 1);
        add_model_read(REG_TIMER_LO);
        add_model_read(REG_READ_DATA);
        add_read(REG_CTL_COUNT, 0);
        add_read(REG_CTL_STATUS, 0);

        // overflow loses the last four records
        add_samples(20);
        add_idle(2);
        add_read(REG_CTL_COUNT, 16);
        add_read(REG_DROP_COUNT, 4);
        add_model_read(REG_CH_BASE);
        add_model_read(REG_TIMER_LO);

        // trim to five and then release the limit
        add_write(REG_LIMIT_SIZE, 5);
        add_idle(30);
        add_read(REG_CTL_COUNT, 5);
        add_read(REG_LIMIT_SIZE, 5);
        add_model_read(REG_CH_BASE);
        add_model_read(REG_TIMER_LO);
        add_write(REG_LIMIT_SIZE, 0);
        add_samples(2);
        add_idle(2);
        add_read(REG_CTL_COUNT, 7);

        // flush mode on and off
        add_write(REG_CTL_CONTROL, 32'h2);
        add_idle(20);
        add_write(REG_CTL_CONTROL, 32'h0);
        add_idle(2);
        add_read(REG_CTL_COUNT, 0);
        add_read(REG_CTL_STATUS, 0);
        add_samples(3);
        add_idle(2);
        add_read(REG_CTL_COUNT, 3);
        add_model_read(BUS_AW'(REG_CH_BASE + 1));
        add_model_read(REG_TIMER_HI);
        add_model_read(REG_READ_DATA);
        add_read(REG_CTL_COUNT, 2);

        timeout_limit = 20 * steps.size();

        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        cyc   = '0;

        foreach (steps[i]) begin
            apply_step(steps[i]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: vlog.f
logic/logger_pkg.sv
logic/sample_stamper.sv
logic/log_fifo.sv
logic/log_regs.sv
logic/data_logger.sv
verification/data_logger_tb.sv
